// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpu_tb
RTL_TOP   ?= cpu
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)
	$(VERILATOR) --lint-only $(VFLAGS) +incdir+hdl hdl/cpu_pkg.sv hdl/register_bank.sv \
		hdl/rom.sv hdl/ram.sv hdl/fetch.sv hdl/decode.sv hdl/execute.sv \
		hdl/memory.sv hdl/cpu.sv --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/cpu_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module cpu_sva (
    input logic                   clock,
    input logic                   arst_n,
    input logic                   enable,
    input logic                   trace_valid,
    input logic [`REG_ADDR_W-1:0] trace_rd,
    input logic [`REG_ADDR_W-1:0] rs1,
    input logic [`REG_ADDR_W-1:0] rs2,
    input logic [`XLEN-1:0]       rs1_value,
    input logic [`XLEN-1:0]       rs2_value
);
    int fired = 0; // Failed assertions so far

    // Trace stays quiet in reset and in the first cycle after it
    reset_quiet: assert property (@(posedge clock) !arst_n |-> !trace_valid)
        else begin $error("trace_valid high during reset"); fired++; end
    release_quiet: assert property (@(posedge clock) $rose(arst_n) |-> !trace_valid)
        else begin $error("trace_valid high right after reset"); fired++; end

    frozen_quiet: assert property (@(posedge clock) disable iff (!arst_n)
        !enable |-> !trace_valid)
        else begin $error("trace_valid high with enable low"); fired++; end

    no_x0_write: assert property (@(posedge clock) disable iff (!arst_n)
        trace_valid |-> trace_rd != '0)
        else begin $error("write to x0 on the trace"); fired++; end

    // x0 reads back as zero on both ports
    x0_read_1: assert property (@(posedge clock) disable iff (!arst_n)
        rs1 == '0 |-> rs1_value == '0)
        else begin $error("x0 read nonzero on port 1"); fired++; end
    x0_read_2: assert property (@(posedge clock) disable iff (!arst_n)
        rs2 == '0 |-> rs2_value == '0)
        else begin $error("x0 read nonzero on port 2"); fired++; end

endmodule

`default_nettype wire

// ==== bench/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module cpu_tb;
    localparam int PERIOD = 20;
    localparam int RST_CYCLES = 5;

    logic                          clock;
    logic                          arst_n;
    logic                          enable;
    logic                          prog_we;
    logic [$clog2(`ROM_WORDS)-1:0] prog_addr;
    logic [`XLEN-1:0]              prog_data;
    logic                          trace_valid;
    logic [`REG_ADDR_W-1:0]        trace_rd;
    logic [`XLEN-1:0]              trace_data;

    logic [31:0] prog [$];        // Program under test
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    logic [31:0] model_mem [256];
    logic [4:0]  last1;
    logic [4:0]  last2;
    logic [4:0]  want_rd;
    logic [31:0] want_data;
    int          quiet;
    bit          toggle_on;
    int          stretch;
    time         deadline;

    cpu u_dut (.*);

    bind cpu cpu_sva u_sva (
        .clock, .arst_n, .enable, .trace_valid, .trace_rd,
        .rs1, .rs2, .rs1_value, .rs2_value
    );

    always #(PERIOD / 2) clock = ~clock;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rs1, 3'b000 | {1'b0, opc == 7'h03, 1'b0}, rd, opc}; // LW has funct3 010
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    // Sources avoid the two most recent destinations
    function automatic logic [4:0] pick_src();
        logic [4:0] r;
        do r = 5'($urandom_range(0, 31));
        while (r != 0 && (r == last1 || r == last2));
        return r;
    endfunction

    function automatic void emit(input logic [31:0] word, input logic [4:0] rd);
        prog.push_back(word);
        last2 = last1;
        last1 = rd;
    endfunction

    function automatic void gen_alu();
        logic [4:0] rd;
        logic [4:0] a;
        logic [4:0] b;
        int         kind;
        rd   = ($urandom_range(0, 9) == 0) ? 5'd0 : 5'($urandom_range(1, 31));
        a    = pick_src();
        b    = pick_src();
        kind = $urandom_range(0, 7);
        case (kind)
            0: emit(enc_r(7'h00, b, a, 3'b000, rd), rd);
            1: emit(enc_r(7'h20, b, a, 3'b000, rd), rd);
            2: emit(enc_r(7'h00, b, a, 3'b111, rd), rd);
            3: emit(enc_r(7'h00, b, a, 3'b110, rd), rd);
            4: emit(enc_r(7'h00, b, a, 3'b100, rd), rd);
            5: emit(enc_r(7'h00, b, a, 3'b010, rd), rd);
            6: emit(enc_i(12'($urandom), a, rd, 7'h13), rd);
            default: emit({20'($urandom), rd, 7'h37}, rd);
        endcase
    endfunction

    function automatic void begin_program();
        prog.delete();
        last1 = 0;
        last2 = 0;
    endfunction

    function automatic void end_program();
        emit(enc_b(13'd0, 5'd0, 5'd0, 3'b000), 0); // Self-loop
        emit(`NOP_INSTR, 0);
        emit(`NOP_INSTR, 0);
    endfunction

    // ISA model that walks the program and queues every register write
    function automatic void run_model();
        logic [31:0] r [32];
        logic [31:0] ins;
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        logic [31:0] imm_b;
        bit          wr;
        exp_rd.delete();
        exp_data.delete();
        foreach (r[i]) r[i] = '0;
        pc = `RESET_PC;
        for (int step = 0; step < 4096; step++) begin
            ins   = prog[pc >> 2];
            a     = r[ins[19:15]];
            b     = r[ins[24:20]];
            wr    = 1'b1;
            v     = '0;
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            case (ins[6:0])
                7'h33: case (ins[14:12])
                    3'b000:  v = ins[30] ? a - b : a + b;
                    3'b010:  v = {31'd0, $signed(a) < $signed(b)};
                    3'b100:  v = a ^ b;
                    3'b110:  v = a | b;
                    default: v = a & b;
                endcase
                7'h13: v = a + {{20{ins[31]}}, ins[31:20]};
                7'h37: v = {ins[31:12], 12'd0};
                7'h03: v = model_mem[8'((a + {{20{ins[31]}}, ins[31:20]}) >> 2)];
                7'h23: begin
                    model_mem[8'((a + {{20{ins[31]}}, ins[31:25], ins[11:7]}) >> 2)] = b;
                    wr = 1'b0;
                end
                default: begin // BEQ or BNE
                    wr = 1'b0;
                    if (ins[12] ? (a != b) : (a == b)) begin
                        if (imm_b == 0) break;
                        pc = pc + imm_b - 4;
                    end
                end
            endcase
            if (wr && ins[11:7] != 0) begin
                r[ins[11:7]] = v;
                exp_rd.push_back(ins[11:7]);
                exp_data.push_back(v);
            end
            pc = pc + 4;
        end
    endfunction

    // Called on a falling edge, reset takes effect at once
    task automatic pulse_reset();
        arst_n = 1'b0;
        enable = 1'b0;
        repeat (RST_CYCLES) @(negedge clock);
        arst_n = 1'b1;
        enable = 1'b1;
    endtask

    task automatic start_program();
        enable = 1'b0;
        foreach (prog[i]) begin
            @(negedge clock);
            prog_we   = 1'b1;
            prog_addr = i[$clog2(`ROM_WORDS)-1:0];
            prog_data = prog[i];
        end
        @(negedge clock);
        prog_we = 1'b0;
        run_model();
        deadline = $time + (30 * prog.size() + RST_CYCLES) * PERIOD;
        pulse_reset();
    endtask

    task automatic wait_done();
        while (!(exp_rd.size() == 0 && quiet >= 20)) @(negedge clock);
        toggle_on = 1'b0;
        enable    = 1'b1;
    endtask

    // Scoreboard samples at the edge that performs the write
    always @(posedge clock) begin
        if (arst_n && trace_valid) begin
            quiet = 0;
            if (exp_rd.size() == 0) abort_run("Register write on the trace with none expected");
            want_rd   = exp_rd.pop_front();
            want_data = exp_data.pop_front();
            assert (trace_rd == want_rd) else
                abort_run($sformatf("CHECK FAILED trace_rd: got %h expected %h",
                                    trace_rd, want_rd));
            assert (trace_data == want_data) else
                abort_run($sformatf("CHECK FAILED trace_data: got %h expected %h",
                                    trace_data, want_data));
        end else begin
            quiet++;
        end
    end

    // Random enable stretches
    always @(negedge clock) begin
        if (toggle_on && arst_n) begin
            if (stretch > 0) begin
                stretch--;
                enable = stretch == 0;
            end else if ($urandom_range(0, 7) == 0) begin
                stretch = $urandom_range(1, 6);
                enable  = 1'b0;
            end
        end
    end

    always @(negedge clock) begin
        if (deadline != 0 && $time > deadline) abort_run("Timeout, program did not finish");
        if (u_dut.u_sva.fired != 0) abort_run("Assertion in cpu_sva failed");
    end

    initial begin
        logic [7:0] stored [$];
        void'($urandom(32'hdeaf));
        clock = 0;
        arst_n = 0;
        enable = 0;
        prog_we = 0;
        prog_addr = '0;
        prog_data = '0;
        toggle_on = 0;
        stretch = 0;
        deadline = 0;
        quiet = 0;

        begin_program(); // Random ALU with x0 writes
        repeat (40) gen_alu();
        end_program();
        start_program();
        wait_done();

        begin_program(); // Stores then loads
        repeat (10) gen_alu();
        repeat (20) begin
            if (stored.size() == 0 || $urandom_range(0, 1) == 0) begin
                stored.push_back(8'($urandom));
                emit(enc_s({2'b00, stored[$], 2'b00}, pick_src()), 0);
            end else begin
                want_rd = 5'($urandom_range(1, 31));
                emit(enc_i({2'b00, stored[$urandom_range(0, stored.size() - 1)], 2'b00},
                           5'd0, want_rd, 7'h03), want_rd);
            end
        end
        end_program();
        start_program();
        wait_done();

        begin_program(); // Branches with marker ADDIs in the shadow
        repeat (10) gen_alu();
        for (int k = 0; k < 12; k++) begin
            want_rd = pick_src();
            emit(enc_b(13'd12, $urandom_range(0, 1) ? want_rd : pick_src(), want_rd,
                       3'($urandom_range(0, 1))), 0);
            for (int s = 0; s < 2; s++) begin
                want_rd = 5'($urandom_range(1, 31));
                emit(enc_i(12'h7a0 + 12'(2 * k + s), 5'd0, want_rd, 7'h13), want_rd);
            end
            repeat (2) gen_alu();
        end
        end_program();
        start_program();
        wait_done();

        begin_program(); // Enable dropped mid-program
        repeat (40) gen_alu();
        end_program();
        start_program();
        toggle_on = 1'b1;
        wait_done();

        begin_program(); // Second reset mid-run
        repeat (30) gen_alu();
        end_program();
        start_program();
        repeat ($urandom_range(10, 30)) @(negedge clock);
        run_model();
        deadline = $time + (30 * prog.size() + RST_CYCLES) * PERIOD;
        pulse_reset();
        wait_done();

        if (u_dut.u_sva.fired == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module cpu (
    input  logic                            clock,
    input  logic                            arst_n,
    input  logic                            enable,
    input  logic                            prog_we,
    input  logic [$clog2(`ROM_WORDS)-1:0]   prog_addr,
    input  logic [`XLEN-1:0]                prog_data,
    output logic                            trace_valid,
    output logic [`REG_ADDR_W-1:0]          trace_rd,
    output logic [`XLEN-1:0]                trace_data
);
    import cpu_pkg::*;

    logic [$clog2(`ROM_WORDS)-1:0] rom_addr;
    logic [`XLEN-1:0]              rom_data;
    logic [$clog2(`RAM_WORDS)-1:0] ram_addr;
    logic [`XLEN-1:0]              ram_wdata;
    logic [`XLEN-1:0]              ram_rdata;
    logic                          ram_we;
    logic [`REG_ADDR_W-1:0]        rs1;
    logic [`REG_ADDR_W-1:0]        rs2;
    logic [`XLEN-1:0]              rs1_value;
    logic [`XLEN-1:0]              rs2_value;
    logic                          redirect;
    logic [`XLEN-1:0]              redirect_pc;
    if_id_t                        if_id;
    id_ex_t                        id_ex;
    ex_mem_t                       ex_mem;

    fetch u_fetch (
        .clock, .arst_n, .enable,
        .redirect, .redirect_pc,
        .rom_addr, .rom_data,
        .if_id
    );

    decode u_decode (
        .clock, .arst_n, .enable,
        .flush (redirect),  // Same edge as the fetch redirect
        .if_id,
        .rs1, .rs2, .rs1_value, .rs2_value,
        .id_ex
    );

    execute u_execute (
        .clock, .arst_n, .enable,
        .id_ex,
        .redirect, .redirect_pc,
        .ex_mem
    );

    // Register bank write port doubles as the trace
    memory u_memory (
        .clock, .arst_n, .enable,
        .ex_mem,
        .ram_addr, .ram_wdata, .ram_we, .ram_rdata,
        .wb_we   (trace_valid),
        .wb_rd   (trace_rd),
        .wb_data (trace_data)
    );

    register_bank u_register_bank (
        .clock, .arst_n,
        .we  (trace_valid),
        .wa  (trace_rd),
        .wd  (trace_data),
        .ra1 (rs1),
        .ra2 (rs2),
        .rd1 (rs1_value),
        .rd2 (rs2_value)
    );

    rom u_rom (
        .clock,
        .addr (rom_addr),
        .data (rom_data),
        .prog_we, .prog_addr, .prog_data
    );

    ram u_ram (
        .clock,
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .we    (ram_we),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

// ==== hdl/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Data path and address width
`define XLEN 32

// Register index width, 32 registers
`define REG_ADDR_W 5

// Memory depths in words
`define ROM_WORDS 256
`define RAM_WORDS 256

`define RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif

// ==== hdl/cpu_pkg.sv ====
`default_nettype none

`include "cpu_consts.svh"

package cpu_pkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_PASS_B = 4'd6 // LUI
    } alu_op_e;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic                  valid;
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      rs1_value;
        logic [`XLEN-1:0]      rs2_value;
        logic [`XLEN-1:0]      imm;
        alu_op_e               alu_op;
        logic                  alu_src_imm;
        logic                  branch;
        logic                  branch_ne;  // BNE when set, BEQ otherwise
        logic                  mem_read;
        logic                  mem_write;
        logic                  reg_write;
        logic [`REG_ADDR_W-1:0] rd;
    } id_ex_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       result;     // ALU result or memory address
        logic [`XLEN-1:0]       store_data;
        logic                   mem_read;
        logic                   mem_write;
        logic                   reg_write;
        logic [`REG_ADDR_W-1:0] rd;
    } ex_mem_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       result;
        logic [`XLEN-1:0]       load_data;
        logic                   mem_to_reg;
        logic                   reg_write;
        logic [`REG_ADDR_W-1:0] rd;
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== hdl/decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module decode (
    input  logic                   clock,
    input  logic                   arst_n,
    input  logic                   enable,
    input  logic                   flush,
    input  cpu_pkg::if_id_t        if_id,
    output logic [`REG_ADDR_W-1:0] rs1,
    output logic [`REG_ADDR_W-1:0] rs2,
    input  logic [`XLEN-1:0]       rs1_value,
    input  logic [`XLEN-1:0]       rs2_value,
    output cpu_pkg::id_ex_t        id_ex
);
    import cpu_pkg::*;

    logic [`XLEN-1:0] instr;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic             legal;
    id_ex_t           dec;

    assign instr  = if_id.instr;
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign imm_i = {{(`XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        dec           = '0;
        legal         = 1'b0;
        dec.pc        = if_id.pc;
        dec.rs1_value = rs1_value;
        dec.rs2_value = rs2_value;
        dec.rd        = instr[11:7];
        dec.alu_op    = ALU_ADD;
        case (opcode_e'(instr[6:0]))
            OPC_OP: begin
                dec.reg_write = 1'b1;
                legal         = (funct7 == 7'b0000000);
                case (funct3)
                    3'b000: begin
                        if (funct7 == 7'b0100000) begin
                            legal      = 1'b1;
                            dec.alu_op = ALU_SUB;
                        end
                    end
                    3'b010:  dec.alu_op = ALU_SLT;
                    3'b100:  dec.alu_op = ALU_XOR;
                    3'b110:  dec.alu_op = ALU_OR;
                    3'b111:  dec.alu_op = ALU_AND;
                    default: legal = 1'b0; // Shifts and SLTU
                endcase
            end
            OPC_OP_IMM: begin
                legal           = (funct3 == 3'b000); // ADDI only
                dec.imm         = imm_i;
                dec.alu_src_imm = 1'b1;
                dec.reg_write   = 1'b1;
            end
            OPC_LUI: begin
                legal           = 1'b1;
                dec.imm         = imm_u;
                dec.alu_op      = ALU_PASS_B;
                dec.alu_src_imm = 1'b1;
                dec.reg_write   = 1'b1;
            end
            OPC_LOAD: begin
                legal           = (funct3 == 3'b010); // LW
                dec.imm         = imm_i;
                dec.alu_src_imm = 1'b1;
                dec.mem_read    = 1'b1;
                dec.reg_write   = 1'b1;
            end
            OPC_STORE: begin
                legal           = (funct3 == 3'b010); // SW
                dec.imm         = imm_s;
                dec.alu_src_imm = 1'b1;
                dec.mem_write   = 1'b1;
            end
            OPC_BRANCH: begin
                legal         = (funct3[2:1] == 2'b00); // BEQ, BNE
                dec.imm       = imm_b;
                dec.branch    = 1'b1;
                dec.branch_ne = funct3[0];
            end
            default: legal = 1'b0;
        endcase
        dec.reg_write = dec.reg_write && (dec.rd != '0); // x0 writes dropped here
        dec.valid     = if_id.valid && legal;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            id_ex <= '0;
        end else if (enable) begin
            id_ex <= dec;
            if (flush) begin
                id_ex.valid <= 1'b0; // Branch shadow
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module execute (
    input  logic             clock,
    input  logic             arst_n,
    input  logic             enable,
    input  cpu_pkg::id_ex_t  id_ex,
    output logic             redirect,
    output logic [`XLEN-1:0] redirect_pc,
    output cpu_pkg::ex_mem_t ex_mem
);
    import cpu_pkg::*;

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_result;
    logic             equal;

    assign op_a = id_ex.rs1_value;
    assign op_b = id_ex.alu_src_imm ? id_ex.imm : id_ex.rs2_value;

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:    alu_result = op_a + op_b;
            ALU_SUB:    alu_result = op_a - op_b; // Wraps
            ALU_AND:    alu_result = op_a & op_b;
            ALU_OR:     alu_result = op_a | op_b;
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SLT:    alu_result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = op_a + op_b;
        endcase
    end

    // Branch compare always uses the register value of rs2
    assign equal       = (id_ex.rs1_value == id_ex.rs2_value);
    assign redirect    = id_ex.valid && id_ex.branch && (id_ex.branch_ne ? !equal : equal);
    assign redirect_pc = id_ex.pc + id_ex.imm;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
        end else if (enable) begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.result     <= alu_result;
            ex_mem.store_data <= id_ex.rs2_value;
            ex_mem.mem_read   <= id_ex.mem_read;
            ex_mem.mem_write  <= id_ex.mem_write;
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.rd         <= id_ex.rd;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module fetch (
    input  logic                            clock,
    input  logic                            arst_n,
    input  logic                            enable,
    input  logic                            redirect,
    input  logic [`XLEN-1:0]                redirect_pc,
    output logic [$clog2(`ROM_WORDS)-1:0]   rom_addr,
    input  logic [`XLEN-1:0]                rom_data,
    output cpu_pkg::if_id_t                 if_id
);
    logic [`XLEN-1:0] pc;

    assign rom_addr = pc[$clog2(`ROM_WORDS)+1:2]; // Word index

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc    <= `RESET_PC;
            if_id <= '0;
        end else if (enable) begin
            if (redirect) begin
                // Taken branch in execute, drop the word fetched now
                pc          <= redirect_pc;
                if_id.valid <= 1'b0;
                if_id.pc    <= pc;
                if_id.instr <= `NOP_INSTR;
            end else begin
                pc          <= pc + 'd4;
                if_id.valid <= 1'b1;
                if_id.pc    <= pc;
                if_id.instr <= rom_data;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module memory (
    input  logic                            clock,
    input  logic                            arst_n,
    input  logic                            enable,
    input  cpu_pkg::ex_mem_t                ex_mem,
    output logic [$clog2(`RAM_WORDS)-1:0]   ram_addr,
    output logic [`XLEN-1:0]                ram_wdata,
    output logic                            ram_we,
    input  logic [`XLEN-1:0]                ram_rdata,
    output logic                            wb_we,
    output logic [`REG_ADDR_W-1:0]          wb_rd,
    output logic [`XLEN-1:0]                wb_data
);
    import cpu_pkg::*;

    mem_wb_t mem_wb;

    assign ram_addr  = ex_mem.result[$clog2(`RAM_WORDS)+1:2]; // Word aligned only
    assign ram_wdata = ex_mem.store_data;
    assign ram_we    = ex_mem.valid && ex_mem.mem_write && enable;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb <= '0;
        end else if (enable) begin
            mem_wb.valid      <= ex_mem.valid;
            mem_wb.result     <= ex_mem.result;
            mem_wb.load_data  <= ram_rdata;
            mem_wb.mem_to_reg <= ex_mem.mem_read;
            mem_wb.reg_write  <= ex_mem.reg_write;
            mem_wb.rd         <= ex_mem.rd;
        end
    end

    // Writeback select, also the retirement trace
    assign wb_we   = mem_wb.valid && mem_wb.reg_write && enable;
    assign wb_rd   = mem_wb.rd;
    assign wb_data = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.result;

endmodule

`default_nettype wire

// ==== hdl/ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module ram (
    input  logic                            clock,
    input  logic [$clog2(`RAM_WORDS)-1:0]   addr,
    input  logic [`XLEN-1:0]                wdata,
    input  logic                            we,
    output logic [`XLEN-1:0]                rdata
);
    logic [`XLEN-1:0] mem [`RAM_WORDS];

    always_ff @(posedge clock) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // Loads see the word in the same cycle
    assign rdata = mem[addr];

endmodule

`default_nettype wire

// ==== hdl/register_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module register_bank (
    input  logic                   clock,
    input  logic                   arst_n,
    input  logic                   we,
    input  logic [`REG_ADDR_W-1:0] wa,
    input  logic [`XLEN-1:0]       wd,
    input  logic [`REG_ADDR_W-1:0] ra1,
    input  logic [`REG_ADDR_W-1:0] ra2,
    output logic [`XLEN-1:0]       rd1,
    output logic [`XLEN-1:0]       rd2
);
    logic [`XLEN-1:0] regs [1 << `REG_ADDR_W];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < (1 << `REG_ADDR_W); i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin  // x0 never written
            regs[wa] <= wd;
        end
    end

    // Write-first, a read in the write cycle sees the new value
    assign rd1 = (ra1 == '0) ? '0 :
                 (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 :
                 (we && wa == ra2) ? wd : regs[ra2];

endmodule

`default_nettype wire

// ==== hdl/rom.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module rom (
    input  logic                            clock,
    input  logic [$clog2(`ROM_WORDS)-1:0]   addr,
    output logic [`XLEN-1:0]                data,
    input  logic                            prog_we,
    input  logic [$clog2(`ROM_WORDS)-1:0]   prog_addr,
    input  logic [`XLEN-1:0]                prog_data
);
    logic [`XLEN-1:0] mem [`ROM_WORDS];

    // Program load port
    always_ff @(posedge clock) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    assign data = mem[addr]; // Fetch reads combinationally

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hdl
hdl/cpu_pkg.sv
hdl/register_bank.sv
hdl/rom.sv
hdl/ram.sv
hdl/fetch.sv
hdl/decode.sv
hdl/execute.sv
hdl/memory.sv
hdl/cpu.sv
bench/cpu_sva.sv
bench/cpu_tb.sv
